// ==== hw/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // architectural widths
    localparam int xlen      = 32;
    localparam int pfn_width = 20;

    // cacheable, noncoherent, write-back
    localparam logic [2:0] cca_cached = 3'b011;

    // cause.exccode values used by the data side
    typedef enum logic [4:0] {
        exc_int    = 5'd0,
        exc_tlbmod = 5'd1,
        exc_tlbl   = 5'd2,
        exc_tlbs   = 5'd3,
        exc_adel   = 5'd4,
        exc_ades   = 5'd5,
        exc_ov     = 5'd12,
        exc_trap   = 5'd13
    } exc_code_t;

    typedef enum logic [1:0] {
        size_byte = 2'd0,
        size_half = 2'd1,
        size_word = 2'd2
    } acc_size_t;

    // left is lwl/swl, right is lwr/swr
    typedef enum logic [1:0] {
        part_none  = 2'd0,
        part_left  = 2'd1,
        part_right = 2'd2
    } partial_op_t;

endpackage

// ==== hw/addr_translate.sv ====
module addr_translate (
    input  logic [mem_stage_pkg::xlen-1:0]      vaddr,
    input  logic                                access_en,
    input  logic [2:0]                          config_k0,
    input  logic [mem_stage_pkg::pfn_width-1:0] tlb_pfn,
    input  logic [2:0]                          tlb_cca,
    output logic                                mapped,
    output logic [31:0]                         paddr,
    output logic                                uncached
);
    import mem_stage_pkg::*;

    logic kseg0;
    logic seg_mapped;
    logic cached;

    assign kseg0 = (vaddr[31:29] == 3'b100);

    // useg, kseg2 and kseg3 go through the tlb
    assign seg_mapped = ~vaddr[31] | (vaddr[31] & vaddr[30]);
    assign mapped     = seg_mapped & access_en;

    always_comb begin
        if (mapped) begin
            paddr = {tlb_pfn, vaddr[11:0]};   // 4k page
        end else begin
            paddr = {3'b000, vaddr[28:0]};
        end
    end

    // kseg1 never matches either term
    assign cached   = (kseg0 & (config_k0 == cca_cached)) |
                      (mapped & (tlb_cca == cca_cached));
    assign uncached = ~cached;

endmodule

// ==== hw/ll_sc_link.sv ====
module ll_sc_link (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [mem_stage_pkg::xlen-1:0] vaddr,
    input  logic                           access_en,
    input  logic                           is_store,
    input  logic                           ll,
    input  logic                           sc,
    input  logic                           exception,
    input  logic                           eret,
    output logic                           sc_ok,
    output logic                           store_commit,
    output logic                           access_commit
);
    import mem_stage_pkg::*;

    logic            link_bit;
    logic [xlen-1:0] link_addr;

    // clearing wins over a new ll
    always_ff @(posedge clk) begin
        if (reset || exception || eret) begin
            link_bit <= 1'b0;
        end else if (access_en && ll) begin
            link_bit <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (access_en && ll) begin
            link_addr <= vaddr;
        end
    end

    assign sc_ok = link_bit & sc & (link_addr == vaddr);

    // a failed sc neither writes nor requests
    assign access_commit = ~sc | sc_ok;
    assign store_commit  = is_store & access_commit;

endmodule

// ==== hw/mem_exc_detect.sv ====
module mem_exc_detect (
    input  logic [mem_stage_pkg::xlen-1:0]   vaddr,
    input  logic                             mapped,
    input  logic                             is_store,
    input  logic                             is_load,
    input  logic                             store_commit,
    input  mem_stage_pkg::acc_size_t         size,
    input  mem_stage_pkg::partial_op_t       partial_op,
    input  logic                             access_en,
    input  logic                             interrupt,
    input  logic                             overflow,
    input  logic                             trap,
    input  logic                             tlb_found,
    input  logic                             tlb_valid,
    input  logic                             tlb_dirty,
    output logic                             exception,
    output mem_stage_pkg::exc_code_t         exc_code,
    output logic [mem_stage_pkg::xlen-1:0]   badvaddr,
    output logic                             tlb_refill
);
    import mem_stage_pkg::*;

    logic misaligned;
    logic ades;
    logic adel;
    logic entry_bad;
    logic tlbl;
    logic tlbs;
    logic tlbmod;
    logic tlb_exc;

    always_comb begin
        case (size)
            size_half: misaligned = vaddr[0];
            size_word: misaligned = (vaddr[1:0] != 2'b00);
            default:   misaligned = 1'b0;
        endcase
    end

    // lwl/lwr/swl/swr never fault on alignment
    assign ades = access_en & is_store & (partial_op == part_none) & misaligned;
    assign adel = access_en & is_load & (partial_op == part_none) & misaligned;

    assign entry_bad = ~tlb_found | ~tlb_valid;   // refill or invalid

    assign tlbl   = mapped & ~store_commit & entry_bad;
    assign tlbs   = mapped & store_commit & entry_bad;
    assign tlbmod = mapped & store_commit & tlb_found & tlb_valid & ~tlb_dirty;

    assign tlb_exc    = tlbl | tlbs | tlbmod;
    assign tlb_refill = mapped & ~tlb_found;

    assign exception = interrupt | overflow | trap | ades | adel | tlb_exc;

    always_comb begin
        exc_code = exc_int;
        badvaddr = vaddr;
        if (interrupt) begin
            exc_code = exc_int;
            badvaddr = '0;
        end else if (overflow) begin
            exc_code = exc_ov;
            badvaddr = '0;
        end else if (trap) begin
            exc_code = exc_trap;
            badvaddr = '0;
        end else if (ades) begin
            exc_code = exc_ades;
        end else if (adel) begin
            exc_code = exc_adel;
        end else if (tlbl) begin
            exc_code = exc_tlbl;
        end else if (tlbs) begin
            exc_code = exc_tlbs;
        end else if (tlbmod) begin
            exc_code = exc_tlbmod;
        end
    end

endmodule

// ==== hw/mem_req_issue.sv ====
module mem_req_issue (
    input  logic [31:0]                    paddr,
    input  logic                           uncached,
    input  logic                           access_en,
    input  logic                           exception,
    input  logic                           eret,
    input  logic                           store_commit,
    input  logic                           access_commit,
    input  mem_stage_pkg::acc_size_t       size,
    input  mem_stage_pkg::partial_op_t     partial_op,
    input  logic [mem_stage_pkg::xlen-1:0] store_data,
    output logic                           cache_valid,
    output logic                           uncache_valid,
    output logic                           mem_en,
    output logic [3:0]                     wstrb,
    output logic [mem_stage_pkg::xlen-1:0] wdata,
    output logic                           sc_result,
    output logic                           stage_invalid
);
    import mem_stage_pkg::*;

    logic [1:0] lane;
    logic       req;
    logic [4:0] left_shift;
    logic [4:0] right_shift;

    assign lane = paddr[1:0];
    assign req  = access_en & access_commit;

    // byte distance of the register bytes for swl/swr
    assign left_shift  = {~lane, 3'b000};
    assign right_shift = {lane, 3'b000};

    always_comb begin
        wstrb = 4'b0000;
        if (req && store_commit) begin
            case (partial_op)
                part_left: begin
                    case (lane)
                        2'd0:    wstrb = 4'b0001;
                        2'd1:    wstrb = 4'b0011;
                        2'd2:    wstrb = 4'b0111;
                        default: wstrb = 4'b1111;
                    endcase
                end
                part_right: begin
                    case (lane)
                        2'd0:    wstrb = 4'b1111;
                        2'd1:    wstrb = 4'b1110;
                        2'd2:    wstrb = 4'b1100;
                        default: wstrb = 4'b1000;
                    endcase
                end
                default: begin
                    case (size)
                        size_byte: wstrb = 4'b0001 << lane;
                        size_half: wstrb = lane[1] ? 4'b1100 : 4'b0011;
                        default:   wstrb = 4'b1111;
                    endcase
                end
            endcase
        end
    end

    always_comb begin
        case (partial_op)
            part_left:  wdata = store_data >> left_shift;   // msb side to low lanes
            part_right: wdata = store_data << right_shift;
            default: begin
                case (size)
                    size_byte: wdata = {4{store_data[7:0]}};
                    size_half: wdata = {2{store_data[15:0]}};
                    default:   wdata = store_data;
                endcase
            end
        endcase
    end

    assign cache_valid   = req & ~uncached;
    assign uncache_valid = req & uncached;
    assign mem_en        = req & ~exception & ~eret;

    // sc writes 1 back only when the store went out
    assign sc_result     = cache_valid | uncache_valid;
    assign stage_invalid = exception | eret;

endmodule

// ==== hw/mem_access_top.sv ====
module mem_access_top (
    input  logic                                clk,
    input  logic                                reset,
    input  logic                                access_en,
    input  logic                                is_store,
    input  logic                                is_load,
    input  mem_stage_pkg::acc_size_t            size,
    input  mem_stage_pkg::partial_op_t          partial_op,
    input  logic [mem_stage_pkg::xlen-1:0]      vaddr,
    input  logic [mem_stage_pkg::xlen-1:0]      store_data,
    input  logic                                ll,
    input  logic                                sc,
    input  logic                                interrupt,
    input  logic                                overflow,
    input  logic                                trap,
    input  logic                                eret,
    input  logic [2:0]                          config_k0,
    input  logic                                tlb_found,
    input  logic                                tlb_valid,
    input  logic                                tlb_dirty,
    input  logic [mem_stage_pkg::pfn_width-1:0] tlb_pfn,
    input  logic [2:0]                          tlb_cca,
    output logic [31:0]                         paddr,
    output logic                                uncached,
    output logic                                cache_valid,
    output logic                                uncache_valid,
    output logic                                mem_en,
    output logic [3:0]                          wstrb,
    output logic [mem_stage_pkg::xlen-1:0]      wdata,
    output logic                                exception,
    output mem_stage_pkg::exc_code_t            exc_code,
    output logic [mem_stage_pkg::xlen-1:0]      badvaddr,
    output logic                                tlb_refill,
    output logic                                sc_result,
    output logic                                stage_invalid
);
    import mem_stage_pkg::*;

    logic mapped;
    logic sc_ok;    // link hit, probed by the checkers
    logic store_commit;
    logic access_commit;

    addr_translate u_translate (
        .vaddr(vaddr), .access_en(access_en), .config_k0(config_k0),
        .tlb_pfn(tlb_pfn), .tlb_cca(tlb_cca),
        .mapped(mapped), .paddr(paddr), .uncached(uncached)
    );

    ll_sc_link u_link (
        .clk(clk), .reset(reset), .vaddr(vaddr), .access_en(access_en),
        .is_store(is_store), .ll(ll), .sc(sc), .exception(exception), .eret(eret),
        .sc_ok(sc_ok), .store_commit(store_commit), .access_commit(access_commit)
    );

    mem_exc_detect u_exc (
        .vaddr(vaddr), .mapped(mapped), .is_store(is_store), .is_load(is_load),
        .store_commit(store_commit), .size(size), .partial_op(partial_op),
        .access_en(access_en), .interrupt(interrupt), .overflow(overflow), .trap(trap),
        .tlb_found(tlb_found), .tlb_valid(tlb_valid), .tlb_dirty(tlb_dirty),
        .exception(exception), .exc_code(exc_code), .badvaddr(badvaddr),
        .tlb_refill(tlb_refill)
    );

    mem_req_issue u_issue (
        .paddr(paddr), .uncached(uncached), .access_en(access_en),
        .exception(exception), .eret(eret), .store_commit(store_commit),
        .access_commit(access_commit), .size(size), .partial_op(partial_op),
        .store_data(store_data), .cache_valid(cache_valid),
        .uncache_valid(uncache_valid), .mem_en(mem_en), .wstrb(wstrb), .wdata(wdata),
        .sc_result(sc_result), .stage_invalid(stage_invalid)
    );

endmodule

// ==== tb/tb_clock_gen.sv ====
module tb_clock_gen #(
    parameter int period = 8
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #(period / 2) clk = ~clk;
    end

endmodule

// ==== tb/mem_access_properties.sv ====
module mem_access_properties (
    input logic                                clk, reset, access_en,
    input logic                                is_store, is_load, ll, sc,
    input mem_stage_pkg::acc_size_t            size,
    input mem_stage_pkg::partial_op_t          partial_op,
    input logic [mem_stage_pkg::xlen-1:0]      vaddr, store_data,
    input logic                                interrupt, overflow, trap, eret,
    input logic [2:0]                          config_k0, tlb_cca,
    input logic                                tlb_found, tlb_valid, tlb_dirty,
    input logic [mem_stage_pkg::pfn_width-1:0] tlb_pfn,
    input logic [31:0]                         paddr,
    input logic                                uncached, cache_valid, uncache_valid, mem_en,
    input logic [3:0]                          wstrb,
    input logic [mem_stage_pkg::xlen-1:0]      wdata, badvaddr,
    input logic                                exception, tlb_refill, sc_result,
    input mem_stage_pkg::exc_code_t            exc_code,
    input logic                                stage_invalid, sc_ok
);
    import mem_stage_pkg::*;

    int fail_count = 0;

    logic        in_kseg0;
    logic        exp_mapped;
    logic        exp_uncached;
    logic [31:0] exp_paddr;
    logic        model_link;
    logic [31:0] model_addr;
    logic        exp_sc_ok;
    logic        exp_commit;
    logic        exp_store;
    logic        align_fault;
    logic        entry_bad;
    logic        exp_tlbl;
    logic        exp_tlbs;
    logic        exp_tlbmod;
    logic        early_exc;
    logic        exp_exc;
    exc_code_t   exp_code;
    logic [3:0]  exp_wstrb;
    logic [31:0] exp_wdata;
    logic [31:0] lane_mask;

    function automatic void count_failure(input string what);
        fail_count++;
        $error("%s", what);
    endfunction

    assign in_kseg0     = (vaddr[31:29] == 3'b100);
    assign exp_mapped   = access_en && !(vaddr[31:29] == 3'b100 || vaddr[31:29] == 3'b101);
    assign exp_paddr    = exp_mapped ? {tlb_pfn, vaddr[11:0]} : (vaddr & 32'h1fff_ffff);
    assign exp_uncached = !((in_kseg0 && config_k0 == cca_cached) ||
                            (exp_mapped && tlb_cca == cca_cached));

    // reference copy of the link, cleared by reset, exceptions and eret
    always_ff @(posedge clk) begin
        if (reset || exp_exc || eret) begin
            model_link <= 1'b0;
        end else if (access_en && ll) begin
            model_link <= 1'b1;
        end
        if (access_en && ll) begin
            model_addr <= vaddr;
        end
    end

    assign exp_sc_ok  = model_link && sc && (model_addr == vaddr);
    assign exp_commit = !sc || exp_sc_ok;
    assign exp_store  = is_store && exp_commit;

    assign align_fault = access_en && partial_op == part_none &&
                         ((size == size_half && vaddr[0]) ||
                          (size == size_word && vaddr[1:0] != 2'b00));
    assign entry_bad   = !(tlb_found && tlb_valid);
    assign exp_tlbl    = exp_mapped && !exp_store && entry_bad;
    assign exp_tlbs    = exp_mapped && exp_store && entry_bad;
    assign exp_tlbmod  = exp_mapped && exp_store && !entry_bad && !tlb_dirty;
    assign early_exc   = interrupt || overflow || trap;
    assign exp_exc     = early_exc || (align_fault && (is_store || is_load)) ||
                         exp_tlbl || exp_tlbs || exp_tlbmod;

    assign exp_code = interrupt                ? exc_int  :
                      overflow                 ? exc_ov   :
                      trap                     ? exc_trap :
                      (align_fault && is_store) ? exc_ades :
                      (align_fault && is_load)  ? exc_adel :
                      exp_tlbl                 ? exc_tlbl :
                      exp_tlbs                 ? exc_tlbs : exc_tlbmod;

    // per lane: which register byte lands there, if any
    always_comb begin
        int lane;
        int src;
        lane = int'(vaddr[1:0]);
        exp_wstrb = 4'b0000;
        exp_wdata = 32'h0;
        for (int i = 0; i < 4; i++) begin
            src = -1;
            case (partial_op)
                part_left:  src = (i <= lane) ? i + 3 - lane : -1;
                part_right: src = (i >= lane) ? i - lane : -1;
                default: begin
                    if (size == size_word) src = i;
                    else if (size == size_half && i / 2 == lane / 2) src = i % 2;
                    else if (size == size_byte && i == lane) src = 0;
                end
            endcase
            if (src >= 0) begin
                exp_wstrb = exp_wstrb | (4'b0001 << i);
                exp_wdata = exp_wdata | (((store_data >> (8 * src)) & 32'hff) << (8 * i));
            end
        end
        if (!(access_en && exp_store)) exp_wstrb = 4'b0000;
    end

    assign lane_mask = {{8{exp_wstrb[3]}}, {8{exp_wstrb[2]}}, {8{exp_wstrb[1]}}, {8{exp_wstrb[0]}}};

    a_translate: assert property (@(posedge clk) disable iff (reset)
        access_en |-> (paddr == exp_paddr && uncached == exp_uncached))
        else count_failure("paddr or uncached differs from the segment rule");
    a_exc_flag: assert property (@(posedge clk) disable iff (reset)
        exception == exp_exc && tlb_refill == (exp_mapped && !tlb_found))
        else count_failure("exception or tlb_refill differs from the fault rule");
    a_exc_code: assert property (@(posedge clk) disable iff (reset)
        exp_exc |-> (exc_code == exp_code && badvaddr == (early_exc ? 32'h0 : vaddr)))
        else count_failure("exc_code or badvaddr breaks the priority order");
    a_kill: assert property (@(posedge clk) disable iff (reset)
        stage_invalid == (exp_exc || eret) &&
        mem_en == (access_en && exp_commit && !exp_exc && !eret))
        else count_failure("mem_en or stage_invalid wrong around exception or eret");
    a_requests: assert property (@(posedge clk) disable iff (reset)
        cache_valid == (access_en && exp_commit && !exp_uncached) &&
        uncache_valid == (access_en && exp_commit && exp_uncached) &&
        sc_result == (access_en && exp_commit))
        else count_failure("request strobes or sc_result differ from the commit rule");
    a_wstrb: assert property (@(posedge clk) disable iff (reset) wstrb == exp_wstrb)
        else count_failure("wstrb differs from the lane rule");
    a_wdata: assert property (@(posedge clk) disable iff (reset)
        (wdata & lane_mask) == (exp_wdata & lane_mask))
        else count_failure("wdata carries wrong bytes on enabled lanes");
    a_link: assert property (@(posedge clk) disable iff (reset) sc_ok == exp_sc_ok)
        else count_failure("sc link hit differs from the reference link");
    a_idle: assert property (@(posedge clk)
        !access_en |-> (!cache_valid && !uncache_valid && !mem_en && wstrb == 4'b0000))
        else count_failure("request active while access_en is low");

endmodule

bind mem_access_top mem_access_properties props (.*);

// ==== tb/tb_mem_access.sv ====
module tb_mem_access;
    import mem_stage_pkg::*;

    localparam int period       = 8;
    localparam int reset_cycles = 8;
    localparam int unmapped_n   = 64;
    localparam int mapped_n     = 128;
    localparam int priority_n   = 128;
    localparam int idle_n       = 16;
    // 36 store shapes, about 12 link steps, one closing cycle per test
    localparam int total_cycles = reset_cycles + unmapped_n + mapped_n + priority_n +
                                  idle_n + 36 + 16 + 16;

    logic clk, reset, access_en, is_store, is_load, ll, sc;
    logic interrupt, overflow, trap, eret;
    logic tlb_found, tlb_valid, tlb_dirty;
    logic [2:0] config_k0, tlb_cca;
    logic [pfn_width-1:0] tlb_pfn;
    logic [xlen-1:0] vaddr, store_data, wdata, badvaddr;
    acc_size_t size;
    partial_op_t partial_op;
    logic [31:0] paddr;
    logic uncached, cache_valid, uncache_valid, mem_en, exception, tlb_refill;
    logic sc_result, stage_invalid;
    logic [3:0] wstrb;
    exc_code_t exc_code;

    int start_fails;
    int tests_run = 0;
    int tests_failed = 0;
    logic [31:0] link;

    tb_clock_gen #(.period(period)) clock_gen (.clk(clk));

    mem_access_top DUT (.*);

    task automatic clear_inputs();
        {access_en, is_store, is_load, ll, sc, interrupt, overflow, trap, eret} = '0;
        {tlb_found, tlb_valid, tlb_dirty} = 3'b111;
        size       = size_word;
        partial_op = part_none;
        vaddr      = 32'h0;
        store_data = 32'h0;
        config_k0  = cca_cached;
        tlb_cca    = cca_cached;
        tlb_pfn    = '0;
    endtask

    // one access per cycle, driven on the falling edge
    task automatic drive_access(input logic store, input acc_size_t sz,
                                input partial_op_t op, input logic [31:0] addr);
        @(negedge clk);
        clear_inputs();
        access_en  = 1'b1;
        is_store   = store;
        is_load    = ~store;
        size       = sz;
        partial_op = op;
        vaddr      = addr;
        store_data = $urandom;
    endtask

    task automatic begin_test();
        start_fails = DUT.props.fail_count;
    endtask

    task automatic end_test(input string name);
        int n;
        @(negedge clk);
        clear_inputs();
        n = DUT.props.fail_count - start_fails;
        tests_run++;
        if (n == 0) begin
            $display("Pass %s", name);
        end else begin
            tests_failed++;
            $display("Fail %s expected 0 assertion failures actual %0d", name, n);
        end
    endtask

    initial begin
        #(2 * total_cycles * period);
        $display("run timed out after %0d cycles", 2 * total_cycles);
        $display("Checks failed");
        $finish;
    end

    initial begin
        logic [2:0] seg;
        acc_size_t s;
        partial_op_t p;
        void'($urandom(32'hdd4cc1ec));
        reset = 1'b1;
        clear_inputs();
        repeat (reset_cycles) @(negedge clk);
        reset = 1'b0;

        begin_test();
        repeat (unmapped_n) begin
            drive_access(1'($urandom), size_word, part_none,
                         {2'b10, 1'($urandom), 27'($urandom), 2'b00});
            config_k0 = 1'($urandom) ? cca_cached : 3'($urandom);
        end
        end_test("unmapped");

        begin_test();
        repeat (mapped_n) begin
            seg = 3'($urandom);
            if (seg[2]) seg[1] = 1'b1;   // useg, kseg2, kseg3
            drive_access(1'($urandom), size_word, part_none, {seg, 27'($urandom), 2'b00});
            {tlb_found, tlb_valid, tlb_dirty} = 3'($urandom);
            tlb_pfn = 20'($urandom);
            tlb_cca = 1'($urandom) ? cca_cached : 3'($urandom);
        end
        end_test("mapped");

        begin_test();
        repeat (priority_n) begin
            drive_access(1'($urandom), $urandom_range(1, 0) ? size_half : size_word,
                         part_none, {3'b100, 27'($urandom), 2'($urandom)});
            interrupt = ($urandom_range(3, 0) == 0);
            overflow  = ($urandom_range(3, 0) == 0);
            trap      = ($urandom_range(3, 0) == 0);
            eret      = ($urandom_range(3, 0) == 0);
        end
        end_test("priority");

        begin_test();
        s = s.first();
        repeat (3) begin
            p = p.first();
            repeat (3) begin
                for (int off = 0; off < 4; off++) begin
                    drive_access(1'b1, s, p, {2'b10, 1'($urandom), 27'($urandom), 2'(off)});
                end
                p = p.next();
            end
            s = s.next();
        end
        end_test("store_shape");

        begin_test();
        link = {3'b100, 27'($urandom), 2'b00};
        drive_access(1'b0, size_word, part_none, link);
        ll = 1'b1;
        drive_access(1'b1, size_word, part_none, link);
        sc = 1'b1;   // hit
        drive_access(1'b1, size_word, part_none, link ^ 32'h40);
        sc = 1'b1;   // other address
        drive_access(1'b0, size_word, part_none, link);
        ll = 1'b1;
        @(negedge clk);
        clear_inputs();
        eret = 1'b1;
        drive_access(1'b1, size_word, part_none, link);
        sc = 1'b1;
        drive_access(1'b0, size_word, part_none, link);
        ll = 1'b1;
        @(negedge clk);
        clear_inputs();
        interrupt = 1'b1;
        drive_access(1'b1, size_word, part_none, link);
        sc = 1'b1;
        drive_access(1'b0, size_word, part_none, link | 32'h2000_0000);
        ll = 1'b1;   // kseg1 link, uncached sc
        drive_access(1'b1, size_word, part_none, link | 32'h2000_0000);
        sc = 1'b1;
        end_test("ll_sc");

        begin_test();
        repeat (idle_n) begin
            @(negedge clk);
            clear_inputs();
            {is_store, is_load, ll, sc, interrupt, eret} = 6'($urandom);
            vaddr      = $urandom;
            store_data = $urandom;
        end
        drive_access(1'b0, size_word, part_none, link);
        ll = 1'b1;
        @(negedge clk);
        clear_inputs();
        reset = 1'b1;
        @(negedge clk);
        reset = 1'b0;
        drive_access(1'b1, size_word, part_none, link);
        sc = 1'b1;   // link gone after reset
        end_test("reset_idle");

        $display("tests %0d failed %0d assertion failures %0d",
                 tests_run, tests_failed, DUT.props.fail_count);
        if (tests_failed == 0 && DUT.props.fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== mem_access_top.f ====
hw/mem_stage_pkg.sv
hw/addr_translate.sv
hw/ll_sc_link.sv
hw/mem_exc_detect.sv
hw/mem_req_issue.sv
hw/mem_access_top.sv
tb/tb_clock_gen.sv
tb/mem_access_properties.sv
tb/tb_mem_access.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the mem_access_top testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -j 0 -f mem_access_top.f \
        --top-module tb_mem_access -o sim_mem_access; then
    echo "verilator build failed"
    exit 1
fi

# keep going after an assertion error so the testbench reports the totals
output=$(./obj_dir/sim_mem_access +verilator+error+limit+100000)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
